//--- icache_pkg.sv
// Shared widths and encodings for the L1 instruction cache
// Line is 16 bytes, so a fetch returns four 32-bit instructions at once
// Index and tag widths depend on NUM_SETS and are derived in each module
`default_nettype none

package icache_pkg;

  // Byte address, line offset and line width
  localparam int unsigned ADDR_W   = 32;
  localparam int unsigned OFFSET_W = 4;
  localparam int unsigned LINE_W   = 128;

  // Exception code returned by the instruction TLB
  typedef enum logic [1:0] {
    EXC_NONE         = 2'd0,
    EXC_PAGE_FAULT   = 2'd1,
    EXC_ACCESS_FAULT = 2'd2
  } exc_e;

  // Control unit states
  typedef enum logic [2:0] {
    ST_IDLE     = 3'd0,
    ST_LOOKUP   = 3'd1,
    ST_WAIT_TLB = 3'd2,
    ST_REQ_L2   = 3'd3,
    ST_WAIT_L2  = 3'd4,
    ST_REPLAY   = 3'd5,
    ST_FLUSH    = 3'd6
  } cu_state_e;

  // Source of the array index
  typedef enum logic [1:0] {
    SRC_REQ   = 2'd0,
    SRC_HELD  = 2'd1,
    SRC_FLUSH = 2'd2
  } addr_src_e;

endpackage

`default_nettype wire

//--- icache_mem.sv
// Tag, valid and data storage, one bank per way
// Read is synchronous and the output registers hold until the next rd_en_i
// A write and a read of the same set in one cycle return the old contents
// NUM_SETS must be at least 2
`timescale 1ns/1ns
`default_nettype none

module icache_mem #(
  parameter  int NUM_WAYS = 2,
  parameter  int NUM_SETS = 16,
  localparam int IDX_W    = $clog2(NUM_SETS),
  localparam int TAG_W    = icache_pkg::ADDR_W - icache_pkg::OFFSET_W - IDX_W
) (
  input  logic                                      clk_i,
  input  logic                                      rst_ni,
  input  logic                                      rd_en_i,
  input  logic [IDX_W-1:0]                          addr_i,
  input  logic [NUM_WAYS-1:0]                       wr_way_i,
  input  logic                                      clr_all_i,
  input  logic [TAG_W-1:0]                          wr_tag_i,
  input  logic [icache_pkg::LINE_W-1:0]             wr_line_i,
  output logic [NUM_WAYS-1:0][TAG_W-1:0]            tag_o,
  output logic [NUM_WAYS-1:0]                       valid_o,
  output logic [NUM_WAYS-1:0][icache_pkg::LINE_W-1:0] line_o
);

  for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
    logic [TAG_W-1:0]              tag_mem  [NUM_SETS];
    logic [icache_pkg::LINE_W-1:0] line_mem [NUM_SETS];
    logic [NUM_SETS-1:0]           vld_q;
    logic [TAG_W-1:0]              tag_rd_q;
    logic [icache_pkg::LINE_W-1:0] line_rd_q;
    logic                          vld_rd_q;

    // Inferred RAM, tag and line written together on refill
    always_ff @(posedge clk_i) begin
      if (wr_way_i[w]) begin
        tag_mem[addr_i]  <= wr_tag_i;
        line_mem[addr_i] <= wr_line_i;
      end
      if (rd_en_i) begin
        tag_rd_q  <= tag_mem[addr_i];
        line_rd_q <= line_mem[addr_i];
      end
    end

    // Valid bits live in flops so a flush can clear them set by set
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        vld_q    <= '0;
        vld_rd_q <= 1'b0;
      end else begin
        if (clr_all_i) begin
          vld_q[addr_i] <= 1'b0;
        end else if (wr_way_i[w]) begin
          vld_q[addr_i] <= 1'b1;
        end
        if (rd_en_i) begin
          vld_rd_q <= vld_q[addr_i];
        end
      end
    end

    assign tag_o[w]   = tag_rd_q;
    assign line_o[w]  = line_rd_q;
    assign valid_o[w] = vld_rd_q;
  end

endmodule

`default_nettype wire

//--- icache_cmp.sv
// Tag comparison and line select
// At most one way may match, the line is an AND-OR of the matching ways
`timescale 1ns/1ns
`default_nettype none

module icache_cmp #(
  parameter int NUM_WAYS = 2,
  parameter int TAG_W    = 24
) (
  input  logic [NUM_WAYS-1:0][TAG_W-1:0]              tag_i,
  input  logic [NUM_WAYS-1:0]                         valid_i,
  input  logic [NUM_WAYS-1:0][icache_pkg::LINE_W-1:0] line_i,
  input  logic [TAG_W-1:0]                            ptag_i,
  output logic                                        hit_o,
  output logic [icache_pkg::LINE_W-1:0]               line_o
);

  logic [NUM_WAYS-1:0] match;

  always_comb begin
    line_o = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      // Only a valid way can match
      match[w] = valid_i[w] && (tag_i[w] == ptag_i);
      line_o   = line_o | (line_i[w] & {icache_pkg::LINE_W{match[w]}});
    end
  end

  assign hit_o = |match;

endmodule

`default_nettype wire

//--- icache_replace.sv
// Victim choice, lowest invalid way first, else per-set round robin
// The pointer moves past the filled way on every refill
`timescale 1ns/1ns
`default_nettype none

module icache_replace #(
  parameter  int NUM_WAYS = 2,
  parameter  int NUM_SETS = 16,
  localparam int IDX_W    = $clog2(NUM_SETS),
  localparam int PTR_W    = (NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic [IDX_W-1:0]    idx_i,
  input  logic [NUM_WAYS-1:0] valid_i,
  input  logic                update_i,
  output logic [NUM_WAYS-1:0] victim_o
);

  logic [PTR_W-1:0] rr_q [NUM_SETS];
  logic [PTR_W-1:0] victim_idx;
  logic             found;

  always_comb begin
    victim_idx = rr_q[idx_i];
    found      = 1'b0;
    // Scan from way 0 so the lowest invalid one wins
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (!valid_i[w] && !found) begin
        victim_idx = PTR_W'(w);
        found      = 1'b1;
      end
    end
  end

  assign victim_o = NUM_WAYS'(1) << victim_idx;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int s = 0; s < NUM_SETS; s++) begin
        rr_q[s] <= '0;
      end
    end else if (update_i) begin
      // Wrap explicitly, NUM_WAYS need not be a power of two
      if (victim_idx == PTR_W'(NUM_WAYS - 1)) begin
        rr_q[idx_i] <= '0;
      end else begin
        rr_q[idx_i] <= victim_idx + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- icache_cu.sv
// Control unit of the blocking instruction cache
// State register drives the channel valids, response and enables use inputs
// Reset enters the flush, so the cache is ready NUM_SETS cycles later
// abort_i wins over every transition and suppresses the response
`timescale 1ns/1ns
`default_nettype none

module icache_cu #(
  parameter  int NUM_SETS = 16,
  localparam int IDX_W    = $clog2(NUM_SETS)
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  flush_i,
  input  logic                  abort_i,
  input  logic                  req_valid_i,
  input  logic                  tlb_ready_i,
  input  logic                  tlb_resp_valid_i,
  input  icache_pkg::exc_e      tlb_exc_i,
  input  logic                  hit_i,
  input  logic                  l2_ready_i,
  input  logic                  l2_resp_valid_i,
  output logic                  req_ready_o,
  output logic                  resp_valid_o,
  output logic                  tlb_req_valid_o,
  output logic                  l2_req_valid_o,
  output icache_pkg::addr_src_e addr_src_o,
  output logic [IDX_W-1:0]      flush_idx_o,
  output logic                  vaddr_en_o,
  output logic                  tag_en_o,
  output logic                  refill_o,
  output logic                  clr_o,
  output logic                  rd_en_o
);

  icache_pkg::cu_state_e state_q;
  icache_pkg::cu_state_e state_d;
  logic [IDX_W-1:0]      cnt_q;
  logic                  last_set;
  logic                  accept;
  logic                  tlb_done;
  logic                  resolved;
  logic                  replay_q;

  assign last_set = (cnt_q == IDX_W'(NUM_SETS - 1));

  // Ready only in idle and not while a flush or abort is pending
  assign req_ready_o = (state_q == icache_pkg::ST_IDLE) && !flush_i && !abort_i;
  assign accept      = req_ready_o && req_valid_i;

  // A zero-latency TLB answers in the cycle it takes the request
  assign tlb_done = tlb_resp_valid_i &&
                    ((state_q == icache_pkg::ST_WAIT_TLB) ||
                     ((state_q == icache_pkg::ST_LOOKUP) && tlb_ready_i));

  // Hit or exception ends the lookup, a clean miss goes to L2
  assign resolved = tlb_done && (hit_i || (tlb_exc_i != icache_pkg::EXC_NONE));

  // Replay answers the cycle after ST_REPLAY from the re-read array
  assign resp_valid_o = !abort_i && (resolved || replay_q);

  assign tlb_req_valid_o = (state_q == icache_pkg::ST_LOOKUP);
  assign l2_req_valid_o  = (state_q == icache_pkg::ST_REQ_L2);
  assign clr_o           = (state_q == icache_pkg::ST_FLUSH);
  assign flush_idx_o     = cnt_q;
  assign vaddr_en_o      = accept;
  assign tag_en_o        = tlb_done;
  assign refill_o        = (state_q == icache_pkg::ST_WAIT_L2) && l2_resp_valid_i && !abort_i;
  assign rd_en_o         = accept || (state_q == icache_pkg::ST_REPLAY);

  always_comb begin
    unique case (state_q)
      icache_pkg::ST_IDLE:  addr_src_o = icache_pkg::SRC_REQ;
      icache_pkg::ST_FLUSH: addr_src_o = icache_pkg::SRC_FLUSH;
      default:              addr_src_o = icache_pkg::SRC_HELD;
    endcase
  end

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      icache_pkg::ST_IDLE: begin
        if (flush_i) begin
          state_d = icache_pkg::ST_FLUSH;
        end else if (accept) begin
          state_d = icache_pkg::ST_LOOKUP;
        end
      end
      icache_pkg::ST_LOOKUP: begin
        if (tlb_done) begin
          state_d = resolved ? icache_pkg::ST_IDLE : icache_pkg::ST_REQ_L2;
        end else if (tlb_ready_i) begin
          state_d = icache_pkg::ST_WAIT_TLB;
        end
      end
      icache_pkg::ST_WAIT_TLB: begin
        if (tlb_done) begin
          state_d = resolved ? icache_pkg::ST_IDLE : icache_pkg::ST_REQ_L2;
        end
      end
      icache_pkg::ST_REQ_L2: begin
        if (l2_ready_i) begin
          state_d = icache_pkg::ST_WAIT_L2;
        end
      end
      icache_pkg::ST_WAIT_L2: begin
        // Victim written in this cycle
        if (l2_resp_valid_i) begin
          state_d = icache_pkg::ST_REPLAY;
        end
      end
      icache_pkg::ST_REPLAY: state_d = icache_pkg::ST_IDLE;
      icache_pkg::ST_FLUSH: begin
        if (last_set) begin
          state_d = icache_pkg::ST_IDLE;
        end
      end
      default: state_d = icache_pkg::ST_IDLE;
    endcase
    if (abort_i) begin
      state_d = icache_pkg::ST_IDLE;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= icache_pkg::ST_FLUSH;
      cnt_q    <= '0;
      replay_q <= 1'b0;
    end else begin
      state_q  <= state_d;
      replay_q <= (state_q == icache_pkg::ST_REPLAY) && !abort_i;
      // Counter rests at zero outside a flush
      if (abort_i || (state_q != icache_pkg::ST_FLUSH) || last_set) begin
        cnt_q <= '0;
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- icache_l1.sv
// Blocking L1 instruction cache, virtually indexed and physically tagged
// Index bits must lie within the page offset, the TLB never changes them
// One request in flight, responses cannot be stalled by the front end
// l2_req_paddr_o is a line address, the byte offset is dropped
`timescale 1ns/1ns
`default_nettype none

module icache_l1 #(
  parameter  int NUM_WAYS = 2,
  parameter  int NUM_SETS = 16,
  localparam int IDX_W    = $clog2(NUM_SETS),
  localparam int TAG_W    = icache_pkg::ADDR_W - icache_pkg::OFFSET_W - IDX_W
) (
  input  logic                                            clk_i,
  input  logic                                            rst_ni,
  input  logic                                            flush_i,
  input  logic                                            abort_i,
  input  logic                                            req_valid_i,
  input  logic [icache_pkg::ADDR_W-1:0]                   req_vaddr_i,
  output logic                                            req_ready_o,
  output logic                                            resp_valid_o,
  output logic [icache_pkg::ADDR_W-1:0]                   resp_vaddr_o,
  output logic [icache_pkg::LINE_W-1:0]                   resp_line_o,
  output icache_pkg::exc_e                                resp_exc_o,
  output logic                                            tlb_req_valid_o,
  output logic [icache_pkg::ADDR_W-1:0]                   tlb_req_vaddr_o,
  input  logic                                            tlb_ready_i,
  input  logic                                            tlb_resp_valid_i,
  input  logic [TAG_W-1:0]                                tlb_resp_ptag_i,
  input  icache_pkg::exc_e                                tlb_resp_exc_i,
  output logic                                            l2_req_valid_o,
  output logic [icache_pkg::ADDR_W-icache_pkg::OFFSET_W-1:0] l2_req_paddr_o,
  input  logic                                            l2_ready_i,
  input  logic                                            l2_resp_valid_i,
  input  logic [icache_pkg::LINE_W-1:0]                   l2_resp_line_i
);

  logic [icache_pkg::ADDR_W-1:0]              vaddr_q;
  logic [TAG_W-1:0]                           tag_q;
  logic [TAG_W-1:0]                           ptag;
  logic [IDX_W-1:0]                           held_idx;
  logic [IDX_W-1:0]                           flush_idx;
  logic [IDX_W-1:0]                           arr_idx;
  icache_pkg::addr_src_e                      addr_src;
  icache_pkg::exc_e                           exc;
  logic                                       vaddr_en;
  logic                                       tag_en;
  logic                                       refill;
  logic                                       clr;
  logic                                       rd_en;
  logic                                       hit;
  logic [NUM_WAYS-1:0]                        victim;
  logic [NUM_WAYS-1:0][TAG_W-1:0]             way_tag;
  logic [NUM_WAYS-1:0]                        way_valid;
  logic [NUM_WAYS-1:0][icache_pkg::LINE_W-1:0] way_line;
  logic [icache_pkg::LINE_W-1:0]              hit_line;

  // Fetch address, held for the TLB, L2 and response
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      vaddr_q <= '0;
    end else if (abort_i) begin
      vaddr_q <= '0;
    end else if (vaddr_en) begin
      vaddr_q <= req_vaddr_i;
    end
  end

  // Physical tag kept for the refill write and the replay compare
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      tag_q <= '0;
    end else if (abort_i) begin
      tag_q <= '0;
    end else if (tag_en) begin
      tag_q <= tlb_resp_ptag_i;
    end
  end

  assign held_idx = vaddr_q[icache_pkg::OFFSET_W +: IDX_W];

  always_comb begin
    unique case (addr_src)
      icache_pkg::SRC_HELD:  arr_idx = held_idx;
      icache_pkg::SRC_FLUSH: arr_idx = flush_idx;
      default:               arr_idx = req_vaddr_i[icache_pkg::OFFSET_W +: IDX_W];
    endcase
  end

  // Live TLB answer during lookup, held tag for the replay response
  assign ptag = tlb_resp_valid_i ? tlb_resp_ptag_i : tag_q;
  assign exc  = tlb_resp_valid_i ? tlb_resp_exc_i : icache_pkg::EXC_NONE;

  assign tlb_req_vaddr_o = vaddr_q;
  assign resp_vaddr_o    = vaddr_q;
  assign resp_exc_o      = exc;
  assign resp_line_o     = (exc != icache_pkg::EXC_NONE) ? '0 : hit_line;
  assign l2_req_paddr_o  = {tag_q, held_idx};

  icache_mem #(.NUM_WAYS(NUM_WAYS), .NUM_SETS(NUM_SETS)) i_mem (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .rd_en_i   (rd_en),
    .addr_i    (arr_idx),
    .wr_way_i  (refill ? victim : '0),
    .clr_all_i (clr),
    .wr_tag_i  (tag_q),
    .wr_line_i (l2_resp_line_i),
    .tag_o     (way_tag),
    .valid_o   (way_valid),
    .line_o    (way_line)
  );

  icache_cmp #(.NUM_WAYS(NUM_WAYS), .TAG_W(TAG_W)) i_cmp (
    .tag_i   (way_tag),
    .valid_i (way_valid),
    .line_i  (way_line),
    .ptag_i  (ptag),
    .hit_o   (hit),
    .line_o  (hit_line)
  );

  // Valid bits read at lookup stay in the array output until the replay
  icache_replace #(.NUM_WAYS(NUM_WAYS), .NUM_SETS(NUM_SETS)) i_replace (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .idx_i    (held_idx),
    .valid_i  (way_valid),
    .update_i (refill),
    .victim_o (victim)
  );

  icache_cu #(.NUM_SETS(NUM_SETS)) i_cu (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .flush_i          (flush_i),
    .abort_i          (abort_i),
    .req_valid_i      (req_valid_i),
    .tlb_ready_i      (tlb_ready_i),
    .tlb_resp_valid_i (tlb_resp_valid_i),
    .tlb_exc_i        (tlb_resp_exc_i),
    .hit_i            (hit),
    .l2_ready_i       (l2_ready_i),
    .l2_resp_valid_i  (l2_resp_valid_i),
    .req_ready_o      (req_ready_o),
    .resp_valid_o     (resp_valid_o),
    .tlb_req_valid_o  (tlb_req_valid_o),
    .l2_req_valid_o   (l2_req_valid_o),
    .addr_src_o       (addr_src),
    .flush_idx_o      (flush_idx),
    .vaddr_en_o       (vaddr_en),
    .tag_en_o         (tag_en),
    .refill_o         (refill),
    .clr_o            (clr),
    .rd_en_o          (rd_en)
  );

endmodule

`default_nettype wire

//--- icache_l1_sva.sv
// Assertions for the L1 instruction cache, bound to icache_l1
// Channel stability checks are skipped in a cycle where abort_i is high
`timescale 1ns/1ns
`default_nettype none

module icache_l1_sva (
  input logic                   clk_i,
  input logic                   rst_ni,
  input logic                   abort_i,
  input logic                   req_valid_i,
  input logic                   req_ready_i,
  input logic                   resp_valid_i,
  input logic                   tlb_req_valid_i,
  input logic [31:0]            tlb_req_vaddr_i,
  input logic                   tlb_ready_i,
  input logic                   l2_req_valid_i,
  input logic [27:0]            l2_req_paddr_i,
  input logic                   l2_ready_i,
  input icache_pkg::cu_state_e  state_i
);

  int err_cnt = 0;

  // TLB request held until taken
  tlb_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    tlb_req_valid_i && !tlb_ready_i && !abort_i |=>
      tlb_req_valid_i && $stable(tlb_req_vaddr_i))
    else begin
      err_cnt++;
      $error("TLB request dropped or changed before accept");
    end

  // L2 request held until taken
  l2_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    l2_req_valid_i && !l2_ready_i && !abort_i |=>
      l2_req_valid_i && $stable(l2_req_paddr_i))
    else begin
      err_cnt++;
      $error("L2 request dropped or changed before accept");
    end

  // Nothing leaves the cache while the valid bits are cleared
  flush_quiet: assert property (@(posedge clk_i) disable iff (!rst_ni)
    state_i == icache_pkg::ST_FLUSH |->
      !resp_valid_i && !tlb_req_valid_i && !l2_req_valid_i)
    else begin
      err_cnt++;
      $error("Output valid high during flush");
    end

  // A taken request leaves idle, so ready drops
  ready_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_valid_i && req_ready_i |=> !req_ready_i)
    else begin
      err_cnt++;
      $error("Request ready high in the cycle after accept");
    end

endmodule

bind icache_l1 icache_l1_sva i_sva (
  .clk_i           (clk_i),
  .rst_ni          (rst_ni),
  .abort_i         (abort_i),
  .req_valid_i     (req_valid_i),
  .req_ready_i     (req_ready_o),
  .resp_valid_i    (resp_valid_o),
  .tlb_req_valid_i (tlb_req_valid_o),
  .tlb_req_vaddr_i (tlb_req_vaddr_o),
  .tlb_ready_i     (tlb_ready_i),
  .l2_req_valid_i  (l2_req_valid_o),
  .l2_req_paddr_i  (l2_req_paddr_o),
  .l2_ready_i      (l2_ready_i),
  .state_i         (i_cu.state_q)
);

`default_nettype wire

//--- tb_icache_models.sv
// TLB and L2 responder models for the cache testbench
// Random bits come from rnd_i, refreshed by the testbench every cycle
// Responses arrive at least one cycle after the request is taken
// abort_i cancels any pending answer
`timescale 1ns/1ns
`default_nettype none

module tb_icache_tlb #(
  parameter int TAG_W = 24
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             abort_i,
  input  logic [2:0]       rnd_i,
  input  logic             req_valid_i,
  input  logic [31:0]      vaddr_i,
  output logic             ready_o,
  output logic             resp_valid_o,
  output logic [TAG_W-1:0] ptag_o,
  output icache_pkg::exc_e exc_o
);

  logic             busy;
  logic [1:0]       cnt;
  logic [TAG_W-1:0] vtag;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy         <= 1'b0;
      cnt          <= '0;
      vtag         <= '0;
      ready_o      <= 1'b0;
      resp_valid_o <= 1'b0;
      ptag_o       <= '0;
      exc_o        <= icache_pkg::EXC_NONE;
    end else begin
      resp_valid_o <= 1'b0;
      if (abort_i) begin
        busy    <= 1'b0;
        ready_o <= 1'b0;
      end else if (busy) begin
        if (cnt == 0) begin
          // Physical tag flips a few low bits of the virtual tag
          resp_valid_o <= 1'b1;
          ptag_o       <= vtag ^ TAG_W'(5'h15);
          exc_o        <= (vtag[TAG_W-1] && vtag[0]) ? icache_pkg::EXC_PAGE_FAULT
                                                     : icache_pkg::EXC_NONE;
          busy         <= 1'b0;
        end else begin
          cnt <= cnt - 1'b1;
        end
      end else if (req_valid_i && ready_o) begin
        busy    <= 1'b1;
        ready_o <= 1'b0;
        cnt     <= rnd_i[1:0];
        vtag    <= vaddr_i[31 -: TAG_W];
      end else begin
        ready_o <= 1'b1;
      end
    end
  end

endmodule

module tb_icache_l2 (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         abort_i,
  input  logic [2:0]   rnd_i,
  input  logic         req_valid_i,
  input  logic [27:0]  paddr_i,
  output logic         ready_o,
  output logic         resp_valid_o,
  output logic [127:0] line_o
);

  logic        busy;
  logic [1:0]  cnt;
  logic [27:0] pa;
  logic [31:0] h;

  // Fixed line contents per physical line address
  assign h = {4'h0, pa} * 32'h9e3779b1;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy         <= 1'b0;
      cnt          <= '0;
      pa           <= '0;
      ready_o      <= 1'b0;
      resp_valid_o <= 1'b0;
      line_o       <= '0;
    end else begin
      resp_valid_o <= 1'b0;
      if (abort_i) begin
        busy    <= 1'b0;
        ready_o <= 1'b0;
      end else if (busy) begin
        if (cnt == 0) begin
          resp_valid_o <= 1'b1;
          line_o       <= {h, ~h, h ^ 32'h5a5a5a5a, 4'ha, pa};
          busy         <= 1'b0;
        end else begin
          cnt <= cnt - 1'b1;
        end
      end else if (req_valid_i && ready_o) begin
        busy    <= 1'b1;
        ready_o <= 1'b0;
        cnt     <= rnd_i[1:0];
        pa      <= paddr_i;
      end else begin
        // Random ready keeps the request waiting now and then
        ready_o <= rnd_i[2];
      end
    end
  end

endmodule

`default_nettype wire

//--- tb_icache.sv
// Random fetch, flush and abort test of the L1 instruction cache
// Tags come from a small pool and only sets 0 to 3 are used, so lines collide
// Inputs change on the rising edge, outputs are sampled on the falling edge
`timescale 1ns/1ns
`default_nettype none

module tb_icache;

  localparam int      N_OPS       = 400;
  localparam int      NUM_SETS    = 16;
  localparam longint  WATCHDOG_NS = (16 + N_OPS * 40) * 10;

  logic         clk_i;
  logic         rst_ni;
  logic         flush_i;
  logic         abort_i;
  logic         req_valid_i;
  logic [31:0]  req_vaddr_i;
  logic         req_ready_o;
  logic         resp_valid_o;
  logic [31:0]  resp_vaddr_o;
  logic [127:0] resp_line_o;
  icache_pkg::exc_e resp_exc_o;
  logic         tlb_req_valid_o;
  logic [31:0]  tlb_req_vaddr_o;
  logic         tlb_ready_i;
  logic         tlb_resp_valid_i;
  logic [23:0]  tlb_resp_ptag_i;
  icache_pkg::exc_e tlb_resp_exc_i;
  logic         l2_req_valid_o;
  logic [27:0]  l2_req_paddr_o;
  logic         l2_ready_i;
  logic         l2_resp_valid_i;
  logic [127:0] l2_resp_line_i;

  logic [31:0]  lfsr_q;
  logic [2:0]   model_rnd;
  int           l2_cnt;
  logic [27:0]  l2_pa;

  // Reference state of the cache
  logic [23:0]  m_tag [NUM_SETS][2];
  logic         m_vld [NUM_SETS][2];
  int           m_rr  [NUM_SETS];

  icache_l1 #(.NUM_WAYS(2), .NUM_SETS(NUM_SETS)) i_dut (.*);

  tb_icache_tlb #(.TAG_W(24)) i_tlb (
    .clk_i(clk_i), .rst_ni(rst_ni), .abort_i(abort_i), .rnd_i(model_rnd),
    .req_valid_i(tlb_req_valid_o), .vaddr_i(tlb_req_vaddr_o), .ready_o(tlb_ready_i),
    .resp_valid_o(tlb_resp_valid_i), .ptag_o(tlb_resp_ptag_i), .exc_o(tlb_resp_exc_i)
  );

  tb_icache_l2 i_l2 (
    .clk_i(clk_i), .rst_ni(rst_ni), .abort_i(abort_i), .rnd_i(model_rnd),
    .req_valid_i(l2_req_valid_o), .paddr_i(l2_req_paddr_o), .ready_o(l2_ready_i),
    .resp_valid_o(l2_resp_valid_i), .line_o(l2_resp_line_i)
  );

  // Galois LFSR, x^32 + x^22 + x^2 + x + 1, one step per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r      = {r[30:0], lfsr_q[0]};
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h80200003) : (lfsr_q >> 1);
    end
    return r;
  endfunction

  // Same line pattern the L2 model delivers
  function automatic logic [127:0] expected_line(input logic [27:0] pa);
    logic [31:0] h;
    h = {4'h0, pa} * 32'h9e3779b1;
    return {h, ~h, h ^ 32'h5a5a5a5a, 4'ha, pa};
  endfunction

  function automatic logic [23:0] pick_vtag(input logic [2:0] k);
    case (k)
      3'd0:    return 24'h000012;
      3'd1:    return 24'h000034;
      3'd2:    return 24'h000056;
      3'd3:    return 24'h800001;  // faults
      3'd4:    return 24'h800002;
      default: return 24'h000078;
    endcase
  endfunction

  task automatic check_val(input string name, input logic [127:0] got,
                           input logic [127:0] exp);
    if (got !== exp) begin
      $display("** Error at %0t: %s got %0h expected %0h", $time, name, got, exp);
      $display("** FAIL **");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  task automatic wait_ready();
    do @(negedge clk_i); while (!req_ready_o);
  endtask

  task automatic run_flush();
    int n;
    n = 0;
    wait_ready();
    @(posedge clk_i);
    flush_i <= 1'b1;
    @(posedge clk_i);
    flush_i <= 1'b0;
    @(negedge clk_i);
    while (!req_ready_o) begin
      n++;
      @(negedge clk_i);
    end
    check_val("flush busy cycles", n, NUM_SETS);
    for (int s = 0; s < NUM_SETS; s++) begin
      m_vld[s][0] = 1'b0;
      m_vld[s][1] = 1'b0;
    end
  endtask

  // Mode 0 runs to the response, 1 aborts in the TLB wait, 2 in the L2 wait
  task automatic run_fetch(input logic [31:0] va, input int mode);
    logic [23:0] ptag;
    logic [3:0]  idx;
    logic        fault;
    logic        hit;
    int          way;
    int          cnt0;
    int          m;
    idx   = va[7:4];
    ptag  = va[31:8] ^ 24'h15;
    fault = va[31] && va[8];
    hit   = 1'b0;
    way   = m_rr[idx];
    m     = mode;
    for (int w = 1; w >= 0; w--) begin
      if (!m_vld[idx][w]) way = w;
      if (m_vld[idx][w] && m_tag[idx][w] == ptag) hit = 1'b1;
    end
    if (m == 2 && (hit || fault)) m = 1;
    wait_ready();
    cnt0 = l2_cnt;
    @(posedge clk_i);
    req_valid_i <= 1'b1;
    req_vaddr_i <= va;
    @(posedge clk_i);
    req_valid_i <= 1'b0;
    // TLB request goes out the cycle after acceptance
    @(negedge clk_i);
    check_val("tlb_req_valid_o", tlb_req_valid_o, 1);
    check_val("tlb_req_vaddr_o", tlb_req_vaddr_o, va);
    if (m != 0) begin
      // Abort lands in the first cycle an answer could arrive
      if (m == 1) begin
        while (!(tlb_req_valid_o && tlb_ready_i)) @(negedge clk_i);
      end else begin
        while (!(l2_req_valid_o && l2_ready_i)) @(negedge clk_i);
      end
      @(posedge clk_i);
      @(posedge clk_i);
      abort_i <= 1'b1;
      @(negedge clk_i);
      check_val("resp_valid_o", resp_valid_o, 0);
      @(posedge clk_i);
      abort_i <= 1'b0;
      @(negedge clk_i);
      check_val("resp_valid_o", resp_valid_o, 0);
      check_val("req_ready_o", req_ready_o, 1);
    end else begin
      while (!resp_valid_o) @(negedge clk_i);
      check_val("resp_vaddr_o", resp_vaddr_o, va);
      check_val("resp_exc_o", resp_exc_o,
                fault ? icache_pkg::EXC_PAGE_FAULT : icache_pkg::EXC_NONE);
      check_val("resp_line_o", resp_line_o, fault ? '0 : expected_line({ptag, idx}));
      // Hit and fault answer together with the TLB, a refill after the replay
      check_val("tlb_resp_valid_i", tlb_resp_valid_i, (hit || fault) ? 1 : 0);
      check_val("l2 request count", l2_cnt - cnt0, (hit || fault) ? 0 : 1);
      if (!hit && !fault) begin
        check_val("l2_req_paddr_o", l2_pa, {ptag, idx});
        m_tag[idx][way] = ptag;
        m_vld[idx][way] = 1'b1;
        m_rr[idx]       = (way == 1) ? 0 : way + 1;
      end
    end
  endtask

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // Model randomness on the falling edge, stimulus uses the rising edge
  always @(negedge clk_i) begin
    model_rnd <= 3'(take_bits(3));
    if (l2_req_valid_o && l2_ready_i) begin
      l2_cnt <= l2_cnt + 1;
      l2_pa  <= l2_req_paddr_o;
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired, the cache stopped answering");
    $display("** FAIL **");
    $fatal(1, "Timeout");
  end

  // Stop at the first failed assertion of the bound checker
  initial begin
    wait (i_dut.i_sva.err_cnt != 0);
    $display("A bound assertion failed, see the error above");
    $display("** FAIL **");
    $fatal(1, "Assertion failure");
  end

  initial begin
    logic [31:0] va;
    logic [3:0]  op;
    lfsr_q      = 32'h54cc;
    model_rnd   = '0;
    l2_cnt      = 0;
    l2_pa       = '0;
    rst_ni      = 1'b0;
    flush_i     = 1'b0;
    abort_i     = 1'b0;
    req_valid_i = 1'b0;
    req_vaddr_i = '0;
    for (int s = 0; s < NUM_SETS; s++) begin
      m_vld[s][0] = 1'b0;
      m_vld[s][1] = 1'b0;
      m_tag[s][0] = '0;
      m_tag[s][1] = '0;
      m_rr[s]     = 0;
    end
    repeat (16) @(posedge clk_i);
    rst_ni <= 1'b1;
    for (int i = 0; i < N_OPS; i++) begin
      // Stimulus bits are drawn on the rising edge
      @(posedge clk_i);
      op = 4'(take_bits(4));
      va = {pick_vtag(3'(take_bits(3))), 2'b00, 2'(take_bits(2)), 4'(take_bits(4))};
      if (op == 4'd0) begin
        run_flush();
      end else if (op == 4'd1) begin
        run_fetch(va, 1 + int'(take_bits(1)));
      end else begin
        run_fetch(va, 0);
      end
    end
    $display("** PASS **");
    $finish;
  end

endmodule

`default_nettype wire

//--- sim.f
icache_pkg.sv
icache_mem.sv
icache_cmp.sv
icache_replace.sv
icache_cu.sv
icache_l1.sv
icache_l1_sva.sv
tb_icache_models.sv
tb_icache.sv
